/* aes_key_stim.txt */
// one record per key: the cipher key line, then round keys 0 to 10, one per line
// columns are the four 32-bit words of a line, most significant word first
2b7e1516 28aed2a6 abf71588 09cf4f3c
2b7e1516 28aed2a6 abf71588 09cf4f3c
a0fafe17 88542cb1 23a33939 2a6c7605
f2c295f2 7a96b943 5935807a 7359f67f
3d80477d 4716fe3e 1e237e44 6d7a883b
ef44a541 a8525b7f b671253b db0bad00
d4d1c6f8 7c839d87 caf2b8bc 11f915bc
6d88a37a 110b3efd dbf98641 ca0093fd
4e54f70e 5f5fc9f3 84a64fb2 4ea6dc4f
ead27321 b58dbad2 312bf560 7f8d292f
ac7766f3 19fadc21 28d12941 575c006e
d014f9a8 c9ee2589 e13f0cc8 b6630ca6
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
62636363 62636363 62636363 62636363
9b9898c9 f9fbfbaa 9b9898c9 f9fbfbaa
90973450 696ccffa f2f45733 0b0fac99
ee06da7b 876a1581 759e42b2 7e91ee2b
7f2e2b88 f8443e09 8dda7cbb f34b9290
ec614b85 1425758c 99ff0937 6ab49ba7
21751787 3550620b acaf6b3c c61bf09b
0ef90333 3ba96138 97060a04 511dfa9f
b1d4d8e2 8a7db9da 1d7bb3de 4c664941
b4ef5bcb 3e92e211 23e951cf 6f8f188e
00010203 04050607 08090a0b 0c0d0e0f
00010203 04050607 08090a0b 0c0d0e0f
d6aa74fd d2af72fa daa678f1 d6ab76fe
b692cf0b 643dbdf1 be9bc500 6830b3fe
b6ff744e d2c2c9bf 6c590cbf 0469bf41
47f7f7bc 95353e03 f96c32bc fd058dfd
3caaa3e8 a99f9deb 50f3af57 adf622aa
5e390f7d f7a69296 a7553dc1 0aa31f6b
14f9701a e35fe28c 440adf4d 4ea9c026
47438735 a41c65b9 e016baf4 aebf7ad2
549932d1 f0855768 1093ed9c be2c974e
13111d7f e3944a17 f307a78b 4d2b30c5

/* key_expand_top.f */
+incdir+.
aes_key_pkg.sv
aes_sbox_pkg.sv
key_loader.sv
schedule_core.sv
key_word_store.sv
key_schedule_ctrl.sv
key_expand_top.sv
key_expand_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the key expansion testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f key_expand_top.f \
    --top-module key_expand_tb -o key_expand_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/key_expand_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* key_expand_tb.sv */
`timescale 1ns/1ps
`include "aes_key_config.svh"

module key_expand_tb;

    localparam int          CLK_HALF     = 20;
    localparam int          RESET_CYCLES = 5;
    localparam logic [15:0] LFSR_SEED    = 16'd45;
    localparam int          DONE_LATENCY = 47;
    // key line plus the 44 schedule words
    localparam int          REC_WORDS    = `AES_NK + `AES_NUM_WORDS;
    // three keys of expansion and reads plus one restart, all doubled
    localparam int          CYCLE_LIMIT  = 2 * (3 * (50 + 44 + 44) + 100);

    logic        clk;
    logic        reset;
    logic        start;
    logic [31:0] cipher_key;
    logic [1:0]  r_index;
    logic [3:0]  round_key_num;
    logic [31:0] round_key;
    logic        done;

    logic [31:0] stim_mem [0:3*REC_WORDS-1];
    logic [15:0] lfsr;
    int          cycle_count;
    int          error_count;
    int          tests_passed;
    int          tests_failed;

    key_expand_top dut (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .cipher_key    (cipher_key),
        .r_index       (r_index),
        .round_key_num (round_key_num),
        .round_key     (round_key),
        .done          (done)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hb400;
        end
        return state >> 1;
    endfunction

    // one LFSR step per bit taken
    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // start pulse and then the key words from the most significant down
    task automatic send_key(input int rec, input string name);
        @(negedge clk);
        start = 1'b1;
        for (int i = 0; i < `AES_NK; i++) begin
            @(negedge clk);
            start      = 1'b0;
            cipher_key = stim_mem[rec * REC_WORDS + i];
            if (i == 0 && done !== 1'b0) begin
                $display("Mismatch %s: done after start expected 0, actual %b", name, done);
                error_count++;
            end
        end
    endtask

    task automatic wait_done(input string name);
        int edges;
        edges = 3;
        while (done !== 1'b1 && edges <= 2 * DONE_LATENCY) begin
            @(negedge clk);
            edges++;
        end
        if (done !== 1'b1) begin
            $display("%s: done never rose within %0d cycles of start", name, edges);
            error_count++;
        end else if (edges != DONE_LATENCY) begin
            $display("Mismatch %s: done latency expected %0d, actual %0d",
                     name, DONE_LATENCY, edges);
            error_count++;
        end
    endtask

    task automatic check_word(input int rec, input int round, input int idx,
                              input string name);
        logic [31:0] expected;
        expected = stim_mem[rec * REC_WORDS + `AES_NK + round * 4 + idx];
        @(negedge clk);
        round_key_num = 4'(round);
        r_index       = 2'(idx);
        // round_key is combinational from the read address
        @(posedge clk);
        if (round_key !== expected) begin
            $display("Mismatch %s: round %0d word %0d expected %08h, actual %08h",
                     name, round, idx, expected, round_key);
            error_count++;
        end
    endtask

    task automatic read_schedule(input int rec, input string name);
        for (int r = 0; r <= `AES_NR; r++) begin
            for (int i = 0; i < `AES_NK; i++) begin
                check_word(rec, r, i, name);
            end
        end
    endtask

    task automatic random_reads(input int rec, input string name);
        int round;
        int idx;
        for (int n = 0; n < `AES_NUM_WORDS; n++) begin
            take_bits(8, round);
            take_bits(2, idx);
            check_word(rec, round % (`AES_NR + 1), idx, name);
        end
    endtask

    initial begin
        int    errors_before;
        int    delay;
        string test_name;
        clk           = 1'b0;
        reset         = 1'b1;
        start         = 1'b0;
        cipher_key    = '0;
        r_index       = '0;
        round_key_num = '0;
        lfsr          = LFSR_SEED;
        cycle_count   = 0;
        error_count   = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        $readmemh("aes_key_stim.txt", stim_mem);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        errors_before = error_count;
        repeat (2) @(negedge clk);
        if (done !== 1'b0) begin
            $display("Mismatch reset_idle: done expected 0, actual %b", done);
            error_count++;
        end
        finish_test("reset_idle", errors_before);

        // each key replaces the schedule of the one before
        for (int rec = 0; rec < 3; rec++) begin
            test_name     = $sformatf("key%0d_expand", rec + 1);
            errors_before = error_count;
            send_key(rec, test_name);
            wait_done(test_name);
            read_schedule(rec, test_name);
            random_reads(rec, test_name);
            finish_test(test_name, errors_before);
        end

        // key 2 is cut off somewhere between edges 7 and 38 and key 3 then runs in full
        errors_before = error_count;
        take_bits(5, delay);
        send_key(1, "restart");
        repeat (2 + delay) @(negedge clk);
        if (done !== 1'b0) begin
            $display("Mismatch restart: done during expansion expected 0, actual %b", done);
            error_count++;
        end
        send_key(2, "restart");
        wait_done("restart");
        read_schedule(2, "restart");
        finish_test("restart", errors_before);

        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* key_expand_top.sv */
`timescale 1ns/1ps
`include "aes_key_config.svh"

module key_expand_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic [`AES_WORD_W-1:0]  cipher_key,
    input  logic [1:0]              r_index,
    input  logic [3:0]              round_key_num,
    output logic [`AES_WORD_W-1:0]  round_key,
    output logic                    done
);

    logic [`AES_NK*`AES_WORD_W-1:0] key;
    logic                           key_loaded;
    logic                           load_key;
    logic                           wr_en;
    aes_key_pkg::word_idx_t         wr_index;
    aes_key_pkg::key_word_u         prev_word;
    aes_key_pkg::key_word_u         back_word;
    aes_key_pkg::key_word_u         new_word;

    key_loader u_loader (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .cipher_key (cipher_key),
        .key        (key),
        .key_loaded (key_loaded)
    );

    key_schedule_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .key_loaded (key_loaded),
        .load_key   (load_key),
        .wr_en      (wr_en),
        .wr_index   (wr_index),
        .done       (done)
    );

    // wr_index is also the word being built
    schedule_core u_core (
        .word_index (wr_index),
        .prev_word  (prev_word),
        .back_word  (back_word),
        .new_word   (new_word)
    );

    key_word_store u_store (
        .clk           (clk),
        .reset         (reset),
        .key           (key),
        .load_key      (load_key),
        .wr_en         (wr_en),
        .wr_index      (wr_index),
        .new_word      (new_word),
        .prev_word     (prev_word),
        .back_word     (back_word),
        .round_key_num (round_key_num),
        .r_index       (r_index),
        .round_key     (round_key)
    );

endmodule

/* key_schedule_ctrl.sv */
`timescale 1ns/1ps
`include "aes_key_config.svh"

module key_schedule_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    key_loaded,
    output logic                    load_key,
    output logic                    wr_en,
    output aes_key_pkg::word_idx_t  wr_index,
    output logic                    done
);

    localparam aes_key_pkg::word_idx_t FIRST_WORD = `AES_NK;
    localparam aes_key_pkg::word_idx_t LAST_WORD  = `AES_NUM_WORDS - 1;

    aes_key_pkg::sched_state_t state;
    aes_key_pkg::word_idx_t    word_cnt;

    // a start on the same cycle wins over a finishing load
    assign load_key = (state == aes_key_pkg::LOAD) && key_loaded && !start;

    // counter runs one past the last word before leaving EXPAND
    assign wr_en    = (state == aes_key_pkg::EXPAND) && (word_cnt <= LAST_WORD);
    assign wr_index = word_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= aes_key_pkg::IDLE;
            word_cnt <= '0;
            done     <= 1'b0;
        end else if (start) begin
            // abandons any expansion in progress
            state <= aes_key_pkg::LOAD;
            done  <= 1'b0;
        end else begin
            case (state)
                aes_key_pkg::IDLE: begin
                    state <= aes_key_pkg::IDLE;
                end
                aes_key_pkg::LOAD: begin
                    if (key_loaded) begin
                        word_cnt <= FIRST_WORD;
                        state    <= aes_key_pkg::EXPAND;
                    end
                end
                aes_key_pkg::EXPAND: begin
                    if (word_cnt <= LAST_WORD) begin
                        word_cnt <= word_cnt + 1'b1;
                    end else begin
                        state <= aes_key_pkg::DONE;
                    end
                end
                aes_key_pkg::DONE: begin
                    // done holds until the next start
                    done  <= 1'b1;
                    state <= aes_key_pkg::IDLE;
                end
                default: begin
                    state <= aes_key_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

/* key_word_store.sv */
`timescale 1ns/1ps
`include "aes_key_config.svh"

module key_word_store (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [`AES_NK*`AES_WORD_W-1:0]  key,
    input  logic                            load_key,
    input  logic                            wr_en,
    input  aes_key_pkg::word_idx_t          wr_index,
    input  aes_key_pkg::key_word_u          new_word,
    output aes_key_pkg::key_word_u          prev_word,
    output aes_key_pkg::key_word_u          back_word,
    input  logic [3:0]                      round_key_num,
    input  logic [1:0]                      r_index,
    output logic [`AES_WORD_W-1:0]          round_key
);

    aes_key_pkg::key_word_u words [`AES_NUM_WORDS];
    aes_key_pkg::word_idx_t prev_idx;
    aes_key_pkg::word_idx_t back_idx;
    aes_key_pkg::word_idx_t rd_idx;

    assign prev_idx = wr_index - aes_key_pkg::word_idx_t'(1);
    assign back_idx = wr_index - aes_key_pkg::word_idx_t'(`AES_NK);
    // round * 4 + word within the round
    assign rd_idx   = {round_key_num, r_index};

    // out of range indices read as zero
    assign prev_word = (prev_idx < `AES_NUM_WORDS) ? words[prev_idx] : '0;
    assign back_word = (back_idx < `AES_NUM_WORDS) ? words[back_idx] : '0;
    assign round_key = (rd_idx < `AES_NUM_WORDS) ? words[rd_idx].word : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `AES_NUM_WORDS; i++) begin
                words[i] <= '0;
            end
        end else if (load_key) begin
            // cipher key becomes words 0 to 3, msb word first
            for (int i = 0; i < `AES_NK; i++) begin
                words[i].word <= key[(`AES_NK - 1 - i) * `AES_WORD_W +: `AES_WORD_W];
            end
        end else if (wr_en) begin
            words[wr_index] <= new_word;
        end
    end

endmodule

/* schedule_core.sv */
`timescale 1ns/1ps

module schedule_core (
    input  aes_key_pkg::word_idx_t  word_index,
    input  aes_key_pkg::key_word_u  prev_word,
    input  aes_key_pkg::key_word_u  back_word,
    output aes_key_pkg::key_word_u  new_word
);

    logic                    first_of_round;
    aes_key_pkg::round_num_t round_num;
    aes_key_pkg::key_word_u  rot_word;
    aes_key_pkg::key_word_u  sub_word;
    aes_key_pkg::key_word_u  temp_word;

    // every fourth word starts a new round key
    assign first_of_round = (word_index[1:0] == 2'b00);
    assign round_num      = word_index[5:2];

    // RotWord, top byte wraps to the bottom
    assign rot_word.bytes = {prev_word.bytes[1], prev_word.bytes[2],
                             prev_word.bytes[3], prev_word.bytes[0]};

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            sub_word.bytes[i] = aes_sbox_pkg::sbox(rot_word.bytes[i]);
        end
        // rcon only touches the msb
        sub_word.bytes[0] = sub_word.bytes[0] ^ aes_sbox_pkg::rcon_byte(round_num);
    end

    assign temp_word     = first_of_round ? sub_word : prev_word;
    assign new_word.word = back_word.word ^ temp_word.word;

endmodule

/* key_loader.sv */
`timescale 1ns/1ps
`include "aes_key_config.svh"

module key_loader (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic [`AES_WORD_W-1:0]          cipher_key,
    output logic [`AES_NK*`AES_WORD_W-1:0]  key,
    output logic                            key_loaded
);

    logic                        loading;
    logic [$clog2(`AES_NK)-1:0]  word_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loading    <= 1'b0;
            word_cnt   <= '0;
            key_loaded <= 1'b0;
        end else if (start) begin
            // restart even in the middle of a load
            loading    <= 1'b1;
            word_cnt   <= '0;
            key_loaded <= 1'b0;
        end else if (loading) begin
            key_loaded <= (word_cnt == `AES_NK - 1);
            if (word_cnt == `AES_NK - 1) begin
                loading <= 1'b0;
            end
            word_cnt <= word_cnt + 1'b1;
        end else begin
            key_loaded <= 1'b0;
        end
    end

    // first word lands in the top slice
    always_ff @(posedge clk) begin
        if (loading && !start) begin
            key[(`AES_NK - 1 - word_cnt) * `AES_WORD_W +: `AES_WORD_W] <= cipher_key;
        end
    end

endmodule

/* aes_sbox_pkg.sv */
package aes_sbox_pkg;

    // FIPS-197 forward S-box, row major
    localparam logic [7:0] SBOX_TABLE [0:255] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // round constants for rounds 1 to 10, index 0 unused
    localparam logic [7:0] RCON_TABLE [0:10] = '{
        8'h00, 8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    function automatic logic [7:0] sbox(input logic [7:0] byte_in);
        return SBOX_TABLE[byte_in];
    endfunction

    // anything outside 1..10 gives zero
    function automatic logic [7:0] rcon_byte(input logic [3:0] round);
        if (round >= 4'd1 && round <= 4'd10) begin
            return RCON_TABLE[round];
        end
        return 8'h00;
    endfunction

endpackage

/* aes_key_pkg.sv */
`include "aes_key_config.svh"

package aes_key_pkg;

    // schedule word, as a whole or as bytes with the msb byte at index 0
    typedef union packed {
        logic [`AES_WORD_W-1:0]            word;
        logic [0:`AES_WORD_W/8-1][7:0]     bytes;
    } key_word_u;

    // index into the 44-word schedule
    typedef logic [$clog2(`AES_NUM_WORDS)-1:0] word_idx_t;

    // round number, 0 to 10
    typedef logic [3:0] round_num_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        EXPAND,
        DONE
    } sched_state_t;

endpackage

/* aes_key_config.svh */
`ifndef AES_KEY_CONFIG_SVH
`define AES_KEY_CONFIG_SVH

// one schedule word
`define AES_WORD_W 32
// words in the cipher key
`define AES_NK 4
`define AES_NR 10
// full schedule, one key word group per round plus the initial key
`define AES_NUM_WORDS (`AES_NK * (`AES_NR + 1))

`endif
